//--- logic/sw_pkg.sv
package sw_pkg;

    // ########################################
    // Switch dimensions
    // ########################################

    localparam int NUM_PORTS    = 2;
    localparam int NUM_PRIO     = 8;
    localparam int PRIO_W       = 3;
    localparam int ADDR_W       = 6;
    localparam int DATA_W       = 32;
    localparam int QUEUE_DEPTH  = 8;
    localparam int PORT_CREDITS = 4;

    // Derived widths for port index, FIFO pointers and the credit counter
    localparam int PORT_W = $clog2(NUM_PORTS);
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int CRED_W = $clog2(PORT_CREDITS + 1);

    // ########################################
    // Bundles passed between blocks
    // ########################################

    // Enqueued descriptor naming where the cell sits and where it goes
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [PORT_W-1:0] port;
        logic [PRIO_W-1:0] prio;
    } desc_t;

    // One port's request for the shared buffer read port
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    // Cell as it leaves on the egress link
    typedef struct packed {
        logic [PRIO_W-1:0] prio;
        logic [DATA_W-1:0] data;
    } tx_cell_t;

endpackage

//--- logic/port_rd_dispatch.sv
`timescale 1ns/100ps

module port_rd_dispatch
    import sw_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_PRIO-1:0] queue_empty,
    input  logic                update,
    output logic [PRIO_W-1:0]   rd_prior,
    output logic                rd_valid
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECK,
        S_NEXT_MASK,
        S_NEXT_ROUND,
        S_CHECK_ROUND,
        S_RESTART
    } upd_state_t;

    upd_state_t          state;
    logic [NUM_PRIO-1:0] wrr_mask;
    logic [PRIO_W-1:0]   wrr_round;
    logic [NUM_PRIO-1:0] masked_empty;
    logic [NUM_PRIO-1:0] enc_busy;
    logic                any_ready;

    // Bits 0 up to and including prio are set
    function automatic logic [NUM_PRIO-1:0] low_mask(input logic [PRIO_W-1:0] prio);
        return {NUM_PRIO{1'b1}} >> (NUM_PRIO - 1 - prio);
    endfunction

    // Lowest queue index whose busy bit is clear
    function automatic logic [PRIO_W-1:0] first_ready(input logic [NUM_PRIO-1:0] busy);
        logic [PRIO_W-1:0] idx;
        idx = '0;
        for (int i = NUM_PRIO - 1; i >= 0; i--) begin
            if (!busy[i]) idx = PRIO_W'(i);
        end
        return idx;
    endfunction

    assign masked_empty = wrr_mask | queue_empty;

    // ########################################
    // Update machine
    // ########################################

    // A served queue masks itself and everything below it. When nothing is left
    // the round advances, and the round mask hides the queues below the round
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            wrr_mask  <= '0;
            wrr_round <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (update) begin
                        wrr_mask <= low_mask(rd_prior);
                        state    <= S_CHECK;
                    end
                end
                S_CHECK:       state <= (&masked_empty) ? S_NEXT_MASK : S_IDLE;
                S_NEXT_MASK: begin
                    wrr_mask <= low_mask(wrr_round);
                    state    <= S_NEXT_ROUND;
                end
                S_NEXT_ROUND: begin
                    wrr_round <= wrr_round + 1'b1;
                    state     <= S_CHECK_ROUND;
                end
                // Past round 7 the mask covers every queue, so this also restarts
                S_CHECK_ROUND: state <= (&masked_empty) ? S_RESTART : S_IDLE;
                default: begin
                    wrr_mask  <= '0;
                    wrr_round <= '0;
                    state     <= S_IDLE;
                end
            endcase
        end
    end

    // During restart the mask is about to clear, so encode without it
    assign enc_busy = (state == S_RESTART) ? queue_empty : masked_empty;

    always_ff @(posedge clk) begin
        rd_prior <= first_ready(enc_busy);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            any_ready <= 1'b0;
        end else begin
            any_ready <= ~&enc_busy;
        end
    end

    assign rd_valid = (state == S_IDLE) && any_ready;

endmodule

//--- logic/prio_queues.sv
`timescale 1ns/100ps

module prio_queues
    import sw_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  desc_t               push_desc,
    input  logic                pop,
    input  logic [PRIO_W-1:0]   pop_prio,
    output desc_t               pop_desc,
    output logic [NUM_PRIO-1:0] queue_empty
);

    // All eight FIFOs share one array, the queue index selects the upper bits
    desc_t             mem   [NUM_PRIO*QUEUE_DEPTH];
    logic [QPTR_W-1:0] head  [NUM_PRIO];
    logic [QPTR_W-1:0] tail  [NUM_PRIO];
    logic [QPTR_W:0]   count [NUM_PRIO];

    logic [NUM_PRIO-1:0] push_hit;
    logic [NUM_PRIO-1:0] pop_hit;

    always_comb begin
        for (int q = 0; q < NUM_PRIO; q++) begin
            push_hit[q]    = push && (push_desc.prio == PRIO_W'(q));
            pop_hit[q]     = pop && (pop_prio == PRIO_W'(q));
            queue_empty[q] = (count[q] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[{push_desc.prio, tail[push_desc.prio]}] <= push_desc;
        end
    end

    assign pop_desc = mem[{pop_prio, head[pop_prio]}];

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < NUM_PRIO; q++) begin
                head[q]  <= '0;
                tail[q]  <= '0;
                count[q] <= '0;
            end
        end else begin
            for (int q = 0; q < NUM_PRIO; q++) begin
                if (push_hit[q]) tail[q] <= tail[q] + 1'b1;
                if (pop_hit[q]) head[q] <= head[q] + 1'b1;
                case ({push_hit[q], pop_hit[q]})
                    2'b10:   count[q] <= count[q] + 1'b1;
                    2'b01:   count[q] <= count[q] - 1'b1;
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- logic/cell_buffer.sv
`timescale 1ns/100ps

module cell_buffer
    import sw_pkg::*;
(
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  rd_req_t           rd_req,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Data for a granted request appears on the next cycle
    always_ff @(posedge clk) begin
        if (rd_req.valid) begin
            rd_data <= mem[rd_req.addr];
        end
    end

endmodule

//--- logic/buffer_read_arbiter.sv
`timescale 1ns/100ps

module buffer_read_arbiter
    import sw_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  rd_req_t [NUM_PORTS-1:0] port_req,
    output logic [NUM_PORTS-1:0]    grant,
    output rd_req_t                 buf_req
);

    logic [PORT_W-1:0] last_grant;
    logic [PORT_W-1:0] winner;

    // Search starts just after the last port served
    always_comb begin
        int idx;
        grant  = '0;
        winner = last_grant;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = (int'(last_grant) + i) % NUM_PORTS;
            if (port_req[idx].valid && (grant == '0)) begin
                grant[idx] = 1'b1;
                winner     = PORT_W'(idx);
            end
        end
    end

    assign buf_req = (|grant) ? port_req[winner] : '0;

    // Reset so that port 0 wins the first contest
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_grant <= PORT_W'(NUM_PORTS - 1);
        end else if (|grant) begin
            last_grant <= winner;
        end
    end

endmodule

//--- logic/egress_port.sv
`timescale 1ns/100ps

module egress_port
    import sw_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enq_valid,
    input  desc_t             enq_desc,
    output rd_req_t           rd_req,
    input  logic              grant,
    input  logic [DATA_W-1:0] rd_data,
    output logic              tx_valid,
    output tx_cell_t          tx_cell,
    input  logic              tx_credit
);

    desc_t               head_desc;
    logic [NUM_PRIO-1:0] queue_empty;
    logic [PRIO_W-1:0]   rd_prior;
    logic                rd_valid;
    logic                pop;
    logic [CRED_W-1:0]   credits;
    logic [PRIO_W-1:0]   req_prio;
    logic [PRIO_W-1:0]   tx_prio;
    logic                data_due;

    prio_queues queues_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (enq_valid),
        .push_desc   (enq_desc),
        .pop         (pop),
        .pop_prio    (rd_prior),
        .pop_desc    (head_desc),
        .queue_empty (queue_empty)
    );

    port_rd_dispatch dispatch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .queue_empty (queue_empty),
        .update      (pop),
        .rd_prior    (rd_prior),
        .rd_valid    (rd_valid)
    );

    // A credit is taken at the pop, so a cell in flight always holds one
    assign pop = rd_valid && (credits != '0) && (!rd_req.valid || grant);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CRED_W'(PORT_CREDITS);
        end else begin
            case ({pop, tx_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    // ########################################
    // Buffer read and egress
    // ########################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_req   <= '0;
            data_due <= 1'b0;
        end else begin
            if (pop) begin
                rd_req.valid <= 1'b1;
                rd_req.addr  <= head_desc.addr;
            end else if (grant) begin
                rd_req.valid <= 1'b0;
            end
            data_due <= grant;
        end
    end

    // The priority moves on at the grant so a new pop can reuse req_prio
    always_ff @(posedge clk) begin
        if (pop) req_prio <= head_desc.prio;
        if (grant) tx_prio <= req_prio;
    end

    assign tx_valid     = data_due;
    assign tx_cell.prio = tx_prio;
    assign tx_cell.data = rd_data;

endmodule

//--- logic/switch_egress.sv
`timescale 1ns/100ps

module switch_egress
    import sw_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  logic [ADDR_W-1:0]        wr_addr,
    input  logic [DATA_W-1:0]        wr_data,
    input  logic                     enq_valid,
    input  desc_t                    enq_desc,
    output logic [NUM_PORTS-1:0]     tx_valid,
    output tx_cell_t [NUM_PORTS-1:0] tx_cell,
    input  logic [NUM_PORTS-1:0]     tx_credit
);

    rd_req_t [NUM_PORTS-1:0] port_req;
    logic [NUM_PORTS-1:0]    grant;
    logic [NUM_PORTS-1:0]    port_enq;
    rd_req_t                 buf_req;
    logic [DATA_W-1:0]       rd_data;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // Each port takes only the descriptors addressed to it
        assign port_enq[p] = enq_valid && (enq_desc.port == PORT_W'(p));

        egress_port port_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .enq_valid (port_enq[p]),
            .enq_desc  (enq_desc),
            .rd_req    (port_req[p]),
            .grant     (grant[p]),
            .rd_data   (rd_data),
            .tx_valid  (tx_valid[p]),
            .tx_cell   (tx_cell[p]),
            .tx_credit (tx_credit[p])
        );
    end

    buffer_read_arbiter arbiter_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .port_req (port_req),
        .grant    (grant),
        .buf_req  (buf_req)
    );

    cell_buffer buffer_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_req  (buf_req),
        .rd_data (rd_data)
    );

endmodule

//--- sim/switch_egress_chk.sv
`timescale 1ns/100ps

module switch_egress_chk
    import sw_pkg::*;
(
    input logic                 clk,
    input logic                 rst_n,
    input logic [NUM_PORTS-1:0] tx_valid,
    input logic [NUM_PORTS-1:0] tx_credit,
    input logic [NUM_PORTS-1:0] grant
);

    int   in_flight [NUM_PORTS];
    logic reset_seen;

    // Cells sent on the link minus credits handed back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reset_seen <= 1'b1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                in_flight[p] <= 0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                in_flight[p] <= in_flight[p] + int'(tx_valid[p]) - int'(tx_credit[p]);
            end
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("More than one buffer grant is high");

    a_quiet_reset: assert property (@(posedge clk) (!rst_n && reset_seen) |-> tx_valid == '0)
        else $error("tx_valid is high during reset");

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_credit
        a_credit: assert property (@(posedge clk) disable iff (!rst_n)
            tx_valid[p] |-> in_flight[p] < PORT_CREDITS)
            else $error("Port %0d sent a cell without credit", p);
    end

endmodule

bind switch_egress switch_egress_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .tx_valid  (tx_valid),
    .tx_credit (tx_credit),
    .grant     (grant)
);

//--- sim/switch_egress_tb.sv
`timescale 1ns/100ps

module switch_egress_tb
    import sw_pkg::*;
();

    typedef struct packed {
        logic [7:0] port;
        logic [7:0] prio;
        logic [7:0] count;
    } stim_t;

    logic                     clk;
    logic                     rst_n;
    logic                     wr_en;
    logic [ADDR_W-1:0]        wr_addr;
    logic [DATA_W-1:0]        wr_data;
    logic                     enq_valid;
    desc_t                    enq_desc;
    logic [NUM_PORTS-1:0]     tx_valid;
    tx_cell_t [NUM_PORTS-1:0] tx_cell;
    logic [NUM_PORTS-1:0]     tx_credit;

    // Port 0 fills every queue, port 1 only queues 2 and 6
    stim_t stim_tbl [10] = '{
        '{8'd0, 8'd0, 8'd3}, '{8'd0, 8'd1, 8'd1}, '{8'd0, 8'd2, 8'd2}, '{8'd0, 8'd3, 8'd2},
        '{8'd0, 8'd4, 8'd1}, '{8'd0, 8'd5, 8'd3}, '{8'd0, 8'd6, 8'd2}, '{8'd0, 8'd7, 8'd2},
        '{8'd1, 8'd2, 8'd5}, '{8'd1, 8'd6, 8'd6}
    };

    logic [31:0]       lfsr = 32'h8d7ddc8f;
    int                next_addr = 0;
    int                received [NUM_PORTS];
    int                exp_prio [NUM_PORTS][$];
    logic [DATA_W-1:0] fifo_data [NUM_PORTS*NUM_PRIO][$];
    int                left [NUM_PORTS][NUM_PRIO];
    int                total_b [NUM_PORTS];

    switch_egress dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic load_cells(input int p, input int q, input int n);
        logic [DATA_W-1:0] d;
        for (int i = 0; i < n; i++) begin
            d = rand_bits(DATA_W);
            @(negedge clk);
            wr_en         = 1'b1;
            wr_addr       = ADDR_W'(next_addr);
            wr_data       = d;
            enq_valid     = 1'b1;
            enq_desc.addr = ADDR_W'(next_addr);
            enq_desc.port = PORT_W'(p);
            enq_desc.prio = PRIO_W'(q);
            fifo_data[p*NUM_PRIO+q].push_back(d);
            next_addr++;
        end
        @(negedge clk);
        wr_en     = 1'b0;
        enq_valid = 1'b0;
    endtask

    task automatic wait_received(input int p, input int target, input int limit);
        int cycles;
        cycles = 0;
        while (received[p] < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run($sformatf("Timed out waiting for %0d cells on port %0d", target, p));
            end
        end
    endtask

    // Each round serves every loaded queue at or above the round index once
    task automatic predict_order(input int p);
        int  remaining;
        bit  found;
        remaining = 0;
        for (int q = 0; q < NUM_PRIO; q++) remaining += left[p][q];
        while (remaining > 0) begin
            for (int r = 0; r < NUM_PRIO; r++) begin
                found = 1'b0;
                for (int q = r; q < NUM_PRIO; q++) begin
                    if (left[p][q] > 0) begin
                        exp_prio[p].push_back(q);
                        left[p][q]--;
                        remaining--;
                        found = 1'b1;
                    end
                end
                if (!found) break;
            end
        end
    endtask

    // Never lets more than PORT_CREDITS credits pile up in the port
    task automatic return_credits(input int p, input int n, input int base);
        int gap;
        for (int i = 0; i < n; i++) begin
            if (i >= PORT_CREDITS) wait_received(p, base + i - PORT_CREDITS + 1, 300);
            gap = int'(rand_bits(2));
            repeat (gap) @(negedge clk);
            @(negedge clk);
            tx_credit[p] = 1'b1;
            @(negedge clk);
            tx_credit[p] = 1'b0;
        end
    endtask

    always @(negedge clk) begin : monitor
        int q;
        logic [DATA_W-1:0] d;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst_n && tx_valid[p]) begin
                if (exp_prio[p].size() == 0) begin
                    fail_run($sformatf("A cell arrived on port %0d when none was expected", p));
                end
                q = exp_prio[p].pop_front();
                d = fifo_data[p*NUM_PRIO+q].pop_front();
                check_value($sformatf("tx_cell[%0d].prio", p), 64'(tx_cell[p].prio), 64'(q));
                check_value($sformatf("tx_cell[%0d].data", p), 64'(tx_cell[p].data), 64'(d));
                received[p]++;
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        enq_valid = 1'b0;
        enq_desc  = '0;
        tx_credit = '0;
        received  = '{default: 0};
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // ########################################
        // Credits withheld, exactly PORT_CREDITS cells leave
        // ########################################
        for (int i = 0; i < 4; i++) exp_prio[0].push_back(0);
        for (int i = 0; i < 6; i++) exp_prio[1].push_back(3);
        load_cells(0, 0, 4);
        load_cells(1, 3, 6);
        wait_received(0, 4, 200);
        wait_received(1, PORT_CREDITS, 200);
        repeat (40) @(negedge clk);
        check_value("received[1]", 64'(received[1]), 64'(PORT_CREDITS));
        repeat (2) begin
            @(negedge clk);
            tx_credit[1] = 1'b1;
            @(negedge clk);
            tx_credit[1] = 1'b0;
        end
        wait_received(1, 6, 200);
        repeat (10) @(negedge clk);

        // ########################################
        // Table load with both ports at zero credit
        // ########################################
        left    = '{default: '{default: 0}};
        total_b = '{default: 0};
        for (int e = 0; e < 10; e++) begin
            load_cells(int'(stim_tbl[e].port), int'(stim_tbl[e].prio), int'(stim_tbl[e].count));
            left[stim_tbl[e].port][stim_tbl[e].prio] += int'(stim_tbl[e].count);
            total_b[stim_tbl[e].port] += int'(stim_tbl[e].count);
        end
        predict_order(0);
        predict_order(1);
        fork
            return_credits(0, total_b[0], 4);
            return_credits(1, total_b[1], 6);
        join
        wait_received(0, 4 + total_b[0], 300);
        wait_received(1, 6 + total_b[1], 300);

        // A stray extra cell would reach the monitor during this gap
        repeat (20) @(negedge clk);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- files.f
logic/sw_pkg.sv
logic/port_rd_dispatch.sv
logic/prio_queues.sv
logic/cell_buffer.sv
logic/buffer_read_arbiter.sv
logic/egress_port.sv
logic/switch_egress.sv
sim/switch_egress_chk.sv
sim/switch_egress_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= switch_egress_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "No pass line in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
